/* build.f */
design/soc_bus_pkg.sv
design/soc_io_pkg.sv
design/bus_fabric.sv
design/sysctrl_regs.sv
design/gpio_router.sv
design/io_subsys_top.sv
sim/io_checker.sv
sim/tb_top.sv

/* design/bus_fabric.sv */
/*
 * Bus fabric: decodes core requests into the SRAM range and the system
 * control page, drives the SRAM port and muxes the replies back.
 */

`timescale 1ns/1ns

module bus_fabric #(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::core_req_t req_i,
  output soc_bus_pkg::core_rsp_t rsp_o,
  output soc_bus_pkg::ram_req_t  ram_o,
  input  logic [31:0]           ram_rdata_i,
  output logic                  sys_sel_o,
  input  soc_bus_pkg::core_rsp_t sys_rsp_i
);

  // first byte address past the SRAM
  localparam logic [31:0] RAM_BYTES = 32'(4 * MEM_WORDS);

  logic ram_sel;
  logic ram_ready_q;
  logic sys_hit;
  logic core_ready;

  assign sys_hit    = sys_sel_o && sys_rsp_i.ready;
  assign core_ready = sys_hit || ram_ready_q;

  // only the start cycle of an SRAM access, the ready cycle is excluded
  assign ram_sel = req_i.valid && !core_ready && (req_i.addr < RAM_BYTES);

  assign sys_sel_o = req_i.valid && (req_i.addr[31:8] == soc_bus_pkg::SYSCTRL_PAGE);

  assign ram_o.wstrb = ram_sel ? req_i.wstrb : 4'h0;
  assign ram_o.addr  = req_i.addr[15:2];
  assign ram_o.wdata = req_i.wdata;

  // SRAM answers one cycle after the request starts
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= ram_sel;
    end
  end

  // system control first, then SRAM
  always_comb begin
    rsp_o = '0;
    if (sys_hit) begin
      rsp_o = sys_rsp_i;
    end else if (ram_ready_q) begin
      rsp_o.ready = 1'b1;
      rsp_o.rdata = ram_rdata_i;
    end
  end

endmodule

/* design/gpio_router.sv */
/*
 * GPIO router: overrides register driven pads with the crystal, PLL,
 * system clock or trap signal, and picks the GPIO interrupt inputs.
 */

`timescale 1ns/1ns

module gpio_router (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  xtal_i,
  input  logic                  pll_clk_i,
  input  logic                  trap_i,
  input  soc_io_pkg::gpio_pad_t  regs_i,
  input  soc_io_pkg::route_cfg_t route_i,
  input  soc_io_pkg::gpio_vec_t  gpio_in_i,
  output soc_io_pkg::gpio_pad_t  pads_o,
  output logic                  irq7_o,
  output logic                  irq8_o
);

  // first pin of each three-pin group
  localparam int XTAL_PIN = 5;
  localparam int PLL_PIN  = 8;
  localparam int TRAP_PIN = 11;

  logic [2:0]            xtal_hit;
  logic [2:0]            pll_hit;
  logic [2:0]            trap_hit;
  soc_io_pkg::gpio_vec_t owned;

  // A, B, C select the first, second, third pin of a group
  function automatic logic [2:0] sel_onehot(soc_io_pkg::route_sel_t sel);
    logic [2:0] hot;
    hot = 3'b000;
    case (sel)
      soc_io_pkg::ROUTE_A: hot = 3'b001;
      soc_io_pkg::ROUTE_B: hot = 3'b010;
      soc_io_pkg::ROUTE_C: hot = 3'b100;
      default:             hot = 3'b000;
    endcase
    return hot;
  endfunction

  assign xtal_hit = sel_onehot(route_i.xtal_dest);
  assign pll_hit  = sel_onehot(route_i.pll_dest);
  assign trap_hit = sel_onehot(route_i.trap_dest);

  // a nonzero selector takes over its whole group
  always_comb begin
    owned = '0;
    owned[XTAL_PIN +: 3] = {3{|xtal_hit}};
    owned[PLL_PIN +: 3]  = {3{|pll_hit}};
    owned[TRAP_PIN +: 3] = {3{|trap_hit}};
  end

  always_comb begin
    pads_o.out = regs_i.out;
    for (int i = 0; i < 3; i++) begin
      if (xtal_hit[i]) pads_o.out[XTAL_PIN + i] = xtal_i;
      if (trap_hit[i]) pads_o.out[TRAP_PIN + i] = trap_i;
    end
    // pin 10 has no source, it is only released
    if (pll_hit[0]) pads_o.out[PLL_PIN] = pll_clk_i;
    if (pll_hit[1]) pads_o.out[PLL_PIN + 1] = clk_i;
    pads_o.outenb    = (regs_i.outenb & ~owned) | {soc_io_pkg::GPIO_W{~rst_n_i}};
    pads_o.pullupb   = regs_i.pullupb | owned;
    pads_o.pulldownb = regs_i.pulldownb | owned;
  end

  assign irq7_o = |(sel_onehot(route_i.irq7_src) & gpio_in_i[2:0]);
  assign irq8_o = |(sel_onehot(route_i.irq8_src) & gpio_in_i[5:3]);

endmodule

/* design/io_subsys_top.sv */
/*
 * I/O subsystem top: bus fabric, system control registers and GPIO
 * router behind a native core bus, plus the interrupt vector.
 */

`timescale 1ns/1ns

module io_subsys_top #(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  xtal_i,
  input  logic                  pll_clk_i,
  input  logic                  trap_i,
  input  logic                  clk_ext_sel_i,
  input  logic                  irq_pin_i,
  input  logic                  irq_spi_i,
  input  soc_bus_pkg::core_req_t req_i,
  output soc_bus_pkg::core_rsp_t rsp_o,
  output soc_bus_pkg::ram_req_t  ram_o,
  input  logic [31:0]           ram_rdata_i,
  input  soc_io_pkg::gpio_vec_t  gpio_in_i,
  input  soc_io_pkg::hk_info_t   hk_i,
  output soc_io_pkg::gpio_pad_t  pads_o,
  output logic [31:0]           irq_o
);

  logic                   sys_sel;
  soc_bus_pkg::core_rsp_t sys_rsp;
  soc_io_pkg::gpio_pad_t  regs;
  soc_io_pkg::route_cfg_t route;
  logic                   irq7;
  logic                   irq8;

  bus_fabric #(
    .MEM_WORDS(MEM_WORDS)
  ) u_bus_fabric (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .rsp_o      (rsp_o),
    .ram_o      (ram_o),
    .ram_rdata_i(ram_rdata_i),
    .sys_sel_o  (sys_sel),
    .sys_rsp_i  (sys_rsp)
  );

  sysctrl_regs u_sysctrl_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .sel_i        (sys_sel),
    .gpio_in_i    (gpio_in_i),
    .pads_i       (pads_o),
    .hk_i         (hk_i),
    .clk_ext_sel_i(clk_ext_sel_i),
    .rsp_o        (sys_rsp),
    .regs_o       (regs),
    .route_o      (route)
  );

  gpio_router u_gpio_router (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .xtal_i   (xtal_i),
    .pll_clk_i(pll_clk_i),
    .trap_i   (trap_i),
    .regs_i   (regs),
    .route_i  (route),
    .gpio_in_i(gpio_in_i),
    .pads_o   (pads_o),
    .irq7_o   (irq7),
    .irq8_o   (irq8)
  );

  // external pin and housekeeping SPI on 5 and 6, GPIO sources on 7 and 8
  assign irq_o = {23'd0, irq8, irq7, irq_spi_i, irq_pin_i, 5'd0};

endmodule

/* design/soc_bus_pkg.sv */
/*
 * Bus definitions for the I/O subsystem: native core request and
 * response, the SRAM port and the system control address map.
 */

package soc_bus_pkg;

  // native valid/ready request from the core
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } core_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } core_rsp_t;

  // word addressed SRAM port, read data comes back separately
  typedef struct packed {
    logic [3:0]  wstrb;
    logic [13:0] addr;
    logic [31:0] wdata;
  } ram_req_t;

  // upper address bits of the system control page
  localparam logic [23:0] SYSCTRL_PAGE = 24'h03_0000;

  // byte offsets inside the system control page
  typedef enum logic [7:0] {
    GPIO_DATA = 8'h00,
    GPIO_OEB  = 8'h04,
    GPIO_PU   = 8'h08,
    GPIO_PD   = 8'h0C,
    HK_CONFIG = 8'h18,
    HK_ENA    = 8'h1C,
    HK_PLL    = 8'h20,
    HK_MFGR   = 8'h24,
    HK_PROD   = 8'h28,
    HK_MASK   = 8'h2C,
    CLK_SEL   = 8'h30,
    XTAL_DEST = 8'h34,
    PLL_DEST  = 8'h38,
    TRAP_DEST = 8'h3C,
    IRQ7_SRC  = 8'h40,
    IRQ8_SRC  = 8'h44
  } sysctrl_reg_e;

endpackage

/* design/soc_io_pkg.sv */
/*
 * Pad and routing definitions: GPIO pad bundle, routing selector codes,
 * housekeeping read-only words and the decoded register write word.
 */

package soc_io_pkg;

  localparam int GPIO_W = 16;

  typedef logic [GPIO_W-1:0] gpio_vec_t;

  // pad controls, the enables and pulls are active low
  typedef struct packed {
    gpio_vec_t out;
    gpio_vec_t outenb;
    gpio_vec_t pullupb;
    gpio_vec_t pulldownb;
  } gpio_pad_t;

  typedef enum logic [1:0] {
    ROUTE_OFF = 2'd0,
    ROUTE_A   = 2'd1,
    ROUTE_B   = 2'd2,
    ROUTE_C   = 2'd3
  } route_sel_t;

  typedef struct packed {
    route_sel_t xtal_dest;
    route_sel_t pll_dest;
    route_sel_t trap_dest;
    route_sel_t irq7_src;
    route_sel_t irq8_src;
  } route_cfg_t;

  // read-only words reported by the housekeeping SPI
  typedef struct packed {
    logic [7:0]  cfg;
    logic        xtal_ena;
    logic        reg_ena;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [3:0]  pll_trim;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
  } hk_info_t;

  // one write word, seen as pad bits or as a selector code
  typedef union packed {
    struct packed {
      logic [15:0] spare;
      gpio_vec_t   bits;
    } pad;
    struct packed {
      logic [29:0] spare;
      route_sel_t  code;
    } sel;
  } sysctrl_wdata_u;

endpackage

/* design/sysctrl_regs.sv */
/*
 * System control registers: GPIO output, output enable and pull
 * registers, the routing selectors and housekeeping readback.
 * Every selected access completes with a single-cycle ready.
 */

`timescale 1ns/1ns

module sysctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::core_req_t  req_i,
  input  logic                   sel_i,
  input  soc_io_pkg::gpio_vec_t   gpio_in_i,
  input  soc_io_pkg::gpio_pad_t   pads_i,
  input  soc_io_pkg::hk_info_t    hk_i,
  input  logic                   clk_ext_sel_i,
  output soc_bus_pkg::core_rsp_t  rsp_o,
  output soc_io_pkg::gpio_pad_t   regs_o,
  output soc_io_pkg::route_cfg_t  route_o
);

  soc_bus_pkg::sysctrl_reg_e  offset;
  soc_io_pkg::sysctrl_wdata_u wdata;
  soc_io_pkg::gpio_pad_t      regs_q;
  soc_io_pkg::route_cfg_t     route_q;
  logic                       ready_q;
  logic                       access;
  logic [31:0]                rdata_q;
  logic [31:0]                rd_word;
  logic                       rd_hit;

  // byte lanes 0 and 1 of a 16-bit GPIO register
  function automatic soc_io_pkg::gpio_vec_t byte_merge(soc_io_pkg::gpio_vec_t cur,
                                                       soc_io_pkg::gpio_vec_t nxt,
                                                       logic [1:0] be);
    soc_io_pkg::gpio_vec_t res;
    res = cur;
    if (be[0]) res[7:0] = nxt[7:0];
    if (be[1]) res[15:8] = nxt[15:8];
    return res;
  endfunction

  assign offset = soc_bus_pkg::sysctrl_reg_e'(req_i.addr[7:0]);
  assign wdata  = req_i.wdata;
  assign access = sel_i && !ready_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q          <= 1'b0;
      regs_q.out       <= '0;
      regs_q.outenb    <= '1;
      regs_q.pullupb   <= '0;
      regs_q.pulldownb <= '0;
      route_q          <= '{default: soc_io_pkg::ROUTE_OFF};
    end else begin
      ready_q <= access;
      if (access) begin
        case (offset)
          soc_bus_pkg::GPIO_DATA:
            regs_q.out <= byte_merge(regs_q.out, wdata.pad.bits, req_i.wstrb[1:0]);
          soc_bus_pkg::GPIO_OEB:
            regs_q.outenb <= byte_merge(regs_q.outenb, wdata.pad.bits, req_i.wstrb[1:0]);
          soc_bus_pkg::GPIO_PU:
            regs_q.pullupb <= byte_merge(regs_q.pullupb, wdata.pad.bits, req_i.wstrb[1:0]);
          soc_bus_pkg::GPIO_PD:
            regs_q.pulldownb <= byte_merge(regs_q.pulldownb, wdata.pad.bits,
                                           req_i.wstrb[1:0]);
          soc_bus_pkg::XTAL_DEST: if (req_i.wstrb[0]) route_q.xtal_dest <= wdata.sel.code;
          soc_bus_pkg::PLL_DEST:  if (req_i.wstrb[0]) route_q.pll_dest <= wdata.sel.code;
          soc_bus_pkg::TRAP_DEST: if (req_i.wstrb[0]) route_q.trap_dest <= wdata.sel.code;
          soc_bus_pkg::IRQ7_SRC:  if (req_i.wstrb[0]) route_q.irq7_src <= wdata.sel.code;
          soc_bus_pkg::IRQ8_SRC:  if (req_i.wstrb[0]) route_q.irq8_src <= wdata.sel.code;
          default: ;
        endcase
      end
    end
  end

  // readback mux, GPIO_DATA shows final pad outputs over the inputs
  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (offset)
      soc_bus_pkg::GPIO_DATA: rd_word = {pads_i.out, gpio_in_i};
      soc_bus_pkg::GPIO_OEB:  rd_word = 32'(regs_q.outenb);
      soc_bus_pkg::GPIO_PU:   rd_word = 32'(regs_q.pullupb);
      soc_bus_pkg::GPIO_PD:   rd_word = 32'(regs_q.pulldownb);
      soc_bus_pkg::HK_CONFIG: rd_word = 32'(hk_i.cfg);
      soc_bus_pkg::HK_ENA:    rd_word = 32'({hk_i.xtal_ena, hk_i.reg_ena});
      soc_bus_pkg::HK_PLL:
        rd_word = 32'({hk_i.pll_trim, hk_i.pll_cp_ena, hk_i.pll_vco_ena, hk_i.pll_bias_ena});
      soc_bus_pkg::HK_MFGR:   rd_word = 32'(hk_i.mfgr_id);
      soc_bus_pkg::HK_PROD:   rd_word = 32'(hk_i.prod_id);
      soc_bus_pkg::HK_MASK:   rd_word = 32'(hk_i.mask_rev);
      soc_bus_pkg::CLK_SEL:   rd_word = 32'(clk_ext_sel_i);
      soc_bus_pkg::XTAL_DEST: rd_word = 32'(route_q.xtal_dest);
      soc_bus_pkg::PLL_DEST:  rd_word = 32'(route_q.pll_dest);
      soc_bus_pkg::TRAP_DEST: rd_word = 32'(route_q.trap_dest);
      soc_bus_pkg::IRQ7_SRC:  rd_word = 32'(route_q.irq7_src);
      soc_bus_pkg::IRQ8_SRC:  rd_word = 32'(route_q.irq8_src);
      default:                rd_hit = 1'b0;
    endcase
  end

  // unknown offsets leave the last read data in place
  always_ff @(posedge clk_i) begin
    if (access && rd_hit) begin
      rdata_q <= rd_word;
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = rdata_q;
  assign regs_o      = regs_q;
  assign route_o     = route_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

/* sim/io_checker.sv */
/*
 * Bus and pad checker that keeps its own model of the SRAM, the system
 * control registers and the routing, and compares the DUT every cycle.
 */

`timescale 1ns/1ns

module io_checker #(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_bus_pkg::core_req_t req_i,
  input  soc_bus_pkg::core_rsp_t rsp_i,
  input  soc_bus_pkg::ram_req_t  ram_i,
  input  logic                   xtal_i,
  input  logic                   pll_clk_i,
  input  logic                   trap_i,
  input  logic                   clk_ext_sel_i,
  input  logic                   irq_pin_i,
  input  logic                   irq_spi_i,
  input  soc_io_pkg::gpio_vec_t  gpio_in_i,
  input  soc_io_pkg::hk_info_t   hk_i,
  input  soc_io_pkg::gpio_pad_t  pads_i,
  input  logic [31:0]            irq_i,
  output int                     errors_o,
  output int                     checks_o
);

  logic [31:0]            mem [64];
  soc_io_pkg::gpio_pad_t  regs;
  soc_io_pkg::route_cfg_t route;
  soc_io_pkg::gpio_pad_t  pads_exp;
  logic [31:0]            irq_exp;
  logic [3:0]             strb_exp;
  logic                   in_ram;
  logic                   in_sys;
  int                     wait_cnt = 0;
  int                     errors = 0;
  int                     checks = 0;

  assign errors_o = errors;
  assign checks_o = checks;
  assign in_ram   = req_i.addr < 32'(4 * MEM_WORDS);
  assign in_sys   = req_i.addr[31:8] == soc_bus_pkg::SYSCTRL_PAGE;

  // power-up contents of the external SRAM
  function automatic logic [31:0] fill_word(int unsigned idx);
    return 32'hC0DE_0000 ^ (idx * 32'h9E37_79B1);
  endfunction

  function automatic logic [31:0] byte_update(logic [31:0] cur, logic [31:0] nxt,
                                              logic [3:0] be);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = nxt[8*b +: 8];
    end
    return res;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // pad and interrupt rules of the router
  task automatic build_expect();
    logic [15:0] grp;
    grp = '0;
    if (route.xtal_dest != soc_io_pkg::ROUTE_OFF) grp[7:5] = 3'b111;
    if (route.pll_dest != soc_io_pkg::ROUTE_OFF) grp[10:8] = 3'b111;
    if (route.trap_dest != soc_io_pkg::ROUTE_OFF) grp[13:11] = 3'b111;
    pads_exp.out = regs.out;
    if (route.xtal_dest != soc_io_pkg::ROUTE_OFF)
      pads_exp.out[4'(4 + route.xtal_dest)] = xtal_i;
    if (route.trap_dest != soc_io_pkg::ROUTE_OFF)
      pads_exp.out[4'(10 + route.trap_dest)] = trap_i;
    if (route.pll_dest == soc_io_pkg::ROUTE_A) pads_exp.out[8] = pll_clk_i;
    pads_exp.outenb    = rst_n_i ? (regs.outenb & ~grp) : 16'hFFFF;
    pads_exp.pullupb   = regs.pullupb | grp;
    pads_exp.pulldownb = regs.pulldownb | grp;
    irq_exp    = '0;
    irq_exp[5] = irq_pin_i;
    irq_exp[6] = irq_spi_i;
    if (route.irq7_src != soc_io_pkg::ROUTE_OFF)
      irq_exp[7] = gpio_in_i[4'(route.irq7_src - 1)];
    if (route.irq8_src != soc_io_pkg::ROUTE_OFF)
      irq_exp[8] = gpio_in_i[4'(route.irq8_src + 2)];
  endtask

  function automatic logic [31:0] read_exp(logic [7:0] off);
    case (off)
      soc_bus_pkg::GPIO_DATA: return {pads_exp.out, gpio_in_i};
      soc_bus_pkg::GPIO_OEB:  return {16'h0, regs.outenb};
      soc_bus_pkg::GPIO_PU:   return {16'h0, regs.pullupb};
      soc_bus_pkg::GPIO_PD:   return {16'h0, regs.pulldownb};
      soc_bus_pkg::HK_CONFIG: return {24'h0, hk_i.cfg};
      soc_bus_pkg::HK_ENA:    return {30'h0, hk_i.xtal_ena, hk_i.reg_ena};
      soc_bus_pkg::HK_PLL:
        return {25'h0, hk_i.pll_trim, hk_i.pll_cp_ena, hk_i.pll_vco_ena, hk_i.pll_bias_ena};
      soc_bus_pkg::HK_MFGR:   return {20'h0, hk_i.mfgr_id};
      soc_bus_pkg::HK_PROD:   return {24'h0, hk_i.prod_id};
      soc_bus_pkg::HK_MASK:   return {28'h0, hk_i.mask_rev};
      soc_bus_pkg::CLK_SEL:   return {31'h0, clk_ext_sel_i};
      soc_bus_pkg::XTAL_DEST: return {30'h0, route.xtal_dest};
      soc_bus_pkg::PLL_DEST:  return {30'h0, route.pll_dest};
      soc_bus_pkg::TRAP_DEST: return {30'h0, route.trap_dest};
      soc_bus_pkg::IRQ7_SRC:  return {30'h0, route.irq7_src};
      soc_bus_pkg::IRQ8_SRC:  return {30'h0, route.irq8_src};
      default:                return 32'h0;
    endcase
  endfunction

  task automatic sys_write();
    logic [3:0]             lo_be;
    logic                   sel_we;
    soc_io_pkg::route_sel_t code;
    lo_be  = req_i.wstrb & 4'h3;
    sel_we = req_i.wstrb[0];
    code   = soc_io_pkg::route_sel_t'(req_i.wdata[1:0]);
    case (req_i.addr[7:0])
      soc_bus_pkg::GPIO_DATA: regs.out = 16'(byte_update(32'(regs.out), req_i.wdata, lo_be));
      soc_bus_pkg::GPIO_OEB:
        regs.outenb = 16'(byte_update(32'(regs.outenb), req_i.wdata, lo_be));
      soc_bus_pkg::GPIO_PU:
        regs.pullupb = 16'(byte_update(32'(regs.pullupb), req_i.wdata, lo_be));
      soc_bus_pkg::GPIO_PD:
        regs.pulldownb = 16'(byte_update(32'(regs.pulldownb), req_i.wdata, lo_be));
      soc_bus_pkg::XTAL_DEST: if (sel_we) route.xtal_dest = code;
      soc_bus_pkg::PLL_DEST:  if (sel_we) route.pll_dest = code;
      soc_bus_pkg::TRAP_DEST: if (sel_we) route.trap_dest = code;
      soc_bus_pkg::IRQ7_SRC:  if (sel_we) route.irq7_src = code;
      soc_bus_pkg::IRQ8_SRC:  if (sel_we) route.irq8_src = code;
      default: ;
    endcase
  endtask

  // the ready cycle of a request
  task automatic finish_access();
    logic [31:0] mask;
    if (!in_ram && !in_sys) begin
      errors++;
      $display("ERROR t=%0t ready returned for unmapped address %h", $time, req_i.addr);
    end else if (wait_cnt != 1) begin
      errors++;
      $display("ERROR t=%0t ready came %0d cycles after the request instead of 1",
               $time, wait_cnt);
    end
    if (req_i.wstrb != 4'h0 && in_ram) begin
      mem[req_i.addr[7:2]] = byte_update(mem[req_i.addr[7:2]], req_i.wdata, req_i.wstrb);
    end else if (req_i.wstrb != 4'h0 && in_sys) begin
      sys_write();
    end
    build_expect();
    mask = '1;
    // pin 9 carries the system clock and is sampled right on the edge
    if (route.pll_dest == soc_io_pkg::ROUTE_B) mask[25] = 1'b0;
    if (req_i.wstrb == 4'h0 && in_ram) begin
      compare("rsp_o.rdata", rsp_i.rdata, mem[req_i.addr[7:2]]);
    end else if (req_i.wstrb == 4'h0 && in_sys) begin
      compare("rsp_o.rdata", rsp_i.rdata & mask, read_exp(req_i.addr[7:0]) & mask);
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      regs.out       = '0;
      regs.outenb    = '1;
      regs.pullupb   = '0;
      regs.pulldownb = '0;
      route          = '0;
      wait_cnt       = 0;
    end
    strb_exp = '0;
    if (req_i.valid && !rsp_i.ready && wait_cnt == 0 && in_ram) strb_exp = req_i.wstrb;
    compare("ram_o.wstrb", 32'(ram_i.wstrb), 32'(strb_exp));
    // SRAM word address and write data follow the request
    if (req_i.valid) begin
      compare("ram_o.addr", 32'(ram_i.addr), (req_i.addr >> 2) & 32'h3FFF);
      compare("ram_o.wdata", ram_i.wdata, req_i.wdata);
    end
    if (!rsp_i.ready) begin
      compare("rsp_o.rdata", rsp_i.rdata, 32'h0);
    end else if (!req_i.valid) begin
      errors++;
      $display("ERROR t=%0t ready returned without a request", $time);
    end
    if (rst_n_i && req_i.valid && rsp_i.ready) begin
      finish_access();
      wait_cnt = 0;
    end else if (req_i.valid) begin
      wait_cnt++;
    end else begin
      wait_cnt = 0;
    end
    build_expect();
    // pins 9 and 10 outputs are left out
    compare("pads_o.out", 32'(pads_i.out & 16'hF9FF), 32'(pads_exp.out & 16'hF9FF));
    compare("pads_o.outenb", 32'(pads_i.outenb), 32'(pads_exp.outenb));
    compare("pads_o.pullupb", 32'(pads_i.pullupb), 32'(pads_exp.pullupb));
    compare("pads_o.pulldownb", 32'(pads_i.pulldownb), 32'(pads_exp.pulldownb));
    compare("irq_o", irq_i, irq_exp);
  end

endmodule

/* sim/tb_top.sv */
/*
 * Testbench for the I/O subsystem that plays the core on the native bus,
 * models the external SRAM and drives random pad and interrupt inputs.
 */

`timescale 1ns/1ns

module tb_top;

  localparam int unsigned MEM_WORDS = 16384;
  localparam int          TIMEOUT   = 16;
  localparam int          HK_BITS   = $bits(soc_io_pkg::hk_info_t);

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   xtal;
  logic                   pll_clk;
  logic                   trap;
  logic                   clk_ext_sel;
  logic                   irq_pin;
  logic                   irq_spi;
  soc_bus_pkg::core_req_t req;
  soc_bus_pkg::core_rsp_t rsp;
  soc_bus_pkg::ram_req_t  ram;
  logic [31:0]            ram_rdata;
  soc_io_pkg::gpio_vec_t  gpio_in;
  soc_io_pkg::hk_info_t   hk;
  soc_io_pkg::gpio_pad_t  pads;
  logic [31:0]            irq;
  logic [31:0]            sram [64];
  int                     errors;
  int                     checks;
  int                     seen_errors;
  int                     tests_run;
  int                     tests_failed;
  int unsigned            pick;
  bit                     done;

  soc_bus_pkg::sysctrl_reg_e rw_regs [9] = '{
    soc_bus_pkg::GPIO_DATA, soc_bus_pkg::GPIO_OEB, soc_bus_pkg::GPIO_PU,
    soc_bus_pkg::GPIO_PD, soc_bus_pkg::XTAL_DEST, soc_bus_pkg::PLL_DEST,
    soc_bus_pkg::TRAP_DEST, soc_bus_pkg::IRQ7_SRC, soc_bus_pkg::IRQ8_SRC
  };
  soc_bus_pkg::sysctrl_reg_e ro_regs [7] = '{
    soc_bus_pkg::HK_CONFIG, soc_bus_pkg::HK_ENA, soc_bus_pkg::HK_PLL,
    soc_bus_pkg::HK_MFGR, soc_bus_pkg::HK_PROD, soc_bus_pkg::HK_MASK, soc_bus_pkg::CLK_SEL
  };
  logic [31:0] unmapped [4] = '{32'h0001_0000, 32'h0300_0100, 32'h1000_0000, 32'h8000_0040};

  always #20 clk_i = ~clk_i;

  // external SRAM with combinational read and clocked byte writes
  assign ram_rdata = sram[ram.addr[5:0]];

  always @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (ram.wstrb[b]) sram[ram.addr[5:0]][8*b +: 8] <= ram.wdata[8*b +: 8];
    end
  end

  io_subsys_top #(.MEM_WORDS(MEM_WORDS)) DUT (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .xtal_i(xtal), .pll_clk_i(pll_clk), .trap_i(trap),
    .clk_ext_sel_i(clk_ext_sel), .irq_pin_i(irq_pin), .irq_spi_i(irq_spi),
    .req_i(req), .rsp_o(rsp), .ram_o(ram), .ram_rdata_i(ram_rdata),
    .gpio_in_i(gpio_in), .hk_i(hk), .pads_o(pads), .irq_o(irq)
  );

  io_checker #(.MEM_WORDS(MEM_WORDS)) u_checker (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req), .rsp_i(rsp), .ram_i(ram),
    .xtal_i(xtal), .pll_clk_i(pll_clk), .trap_i(trap), .clk_ext_sel_i(clk_ext_sel),
    .irq_pin_i(irq_pin), .irq_spi_i(irq_spi), .gpio_in_i(gpio_in), .hk_i(hk),
    .pads_i(pads), .irq_i(irq), .errors_o(errors), .checks_o(checks)
  );

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // holds valid until ready or the cycle limit and then drops it
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input int limit, output bit got_ready);
    int n;
    n         = 0;
    got_ready = 1'b0;
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    while (!got_ready && n < limit) begin
      next_cycle();
      n++;
      got_ready = rsp.ready;
    end
    next_cycle();
    req = '0;
  endtask

  task automatic mapped_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb);
    bus_access(addr, wdata, wstrb, TIMEOUT, done);
    if (!done) begin
      $display("ERROR: no ready within %0d cycles for address %h", TIMEOUT, addr);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  function automatic logic [31:0] reg_addr(soc_bus_pkg::sysctrl_reg_e off);
    return {soc_bus_pkg::SYSCTRL_PAGE, 8'(off)};
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    if (errors == seen_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - seen_errors);
    end
    seen_errors = errors;
  endtask

  initial begin
    pick         = $urandom(38);
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req          = '0;
    xtal         = 1'b0;
    pll_clk      = 1'b0;
    trap         = 1'b0;
    clk_ext_sel  = 1'b0;
    irq_pin      = 1'b0;
    irq_spi      = 1'b0;
    gpio_in      = 16'($urandom());
    hk           = HK_BITS'({$urandom(), $urandom()});
    seen_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < 64; i++) begin
      sram[i] = 32'hC0DE_0000 ^ (i * 32'h9E37_79B1);
    end
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    mapped_access(reg_addr(soc_bus_pkg::GPIO_OEB), 32'h0, 4'h0);
    mapped_access(reg_addr(soc_bus_pkg::GPIO_DATA), 32'h0, 4'h0);
    end_test("reset state");

    for (int n = 0; n < 24; n++) begin
      pick = $urandom_range(63, 0);
      mapped_access(pick * 4, $urandom(), 4'($urandom_range(15, 1)));
    end
    for (int n = 0; n < 24; n++) begin
      pick = $urandom_range(63, 0);
      mapped_access(pick * 4, 32'h0, 4'h0);
    end
    end_test("sram access");

    for (int n = 0; n < 48; n++) begin
      gpio_in     = 16'($urandom());
      hk          = HK_BITS'({$urandom(), $urandom()});
      clk_ext_sel = 1'($urandom());
      pick        = $urandom_range(2, 0);
      if (pick == 0) begin
        mapped_access(reg_addr(rw_regs[4'($urandom_range(8, 0))]), $urandom(),
                      4'($urandom_range(15, 1)));
      end else if (pick == 1) begin
        mapped_access(reg_addr(rw_regs[4'($urandom_range(8, 0))]), 32'h0, 4'h0);
      end else begin
        mapped_access(reg_addr(ro_regs[3'($urandom_range(6, 0))]), 32'h0, 4'h0);
      end
    end
    end_test("register access");

    for (int n = 0; n < 24; n++) begin
      xtal    = 1'($urandom());
      pll_clk = 1'($urandom());
      trap    = 1'($urandom());
      mapped_access(reg_addr(soc_bus_pkg::XTAL_DEST), $urandom(), 4'h1);
      mapped_access(reg_addr(soc_bus_pkg::PLL_DEST), $urandom(), 4'h1);
      mapped_access(reg_addr(soc_bus_pkg::TRAP_DEST), $urandom(), 4'h1);
      mapped_access(reg_addr(soc_bus_pkg::GPIO_DATA), $urandom(), 4'h3);
      mapped_access(reg_addr(soc_bus_pkg::GPIO_OEB), $urandom(), 4'h3);
    end
    end_test("pad routing");

    for (int n = 0; n < 24; n++) begin
      irq_pin = 1'($urandom());
      irq_spi = 1'($urandom());
      gpio_in = 16'($urandom());
      mapped_access(reg_addr(soc_bus_pkg::IRQ7_SRC), $urandom(), 4'h1);
      mapped_access(reg_addr(soc_bus_pkg::IRQ8_SRC), $urandom(), 4'h1);
    end
    end_test("interrupts");

    for (int n = 0; n < 4; n++) begin
      bus_access(unmapped[2'(n)], $urandom(), 4'hF, 8, done);
      if (!done) begin
        $display("unmapped address %h: no ready in 8 cycles, as expected", unmapped[2'(n)]);
      end
    end
    end_test("unmapped address");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
